// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP      = tb_cpu
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: all.f
+incdir+logic
logic/cpu_pkg.sv
logic/controller.sv
logic/regfile.sv
logic/hazard.sv
logic/datapath.sv
logic/cpu_top.sv
verif/tb_cpu.sv

// File: logic/controller.sv
`timescale 1ns/1ns

module controller (
    input  cpu_pkg::instr_inf dinstrinf,
    output cpu_pkg::ctrl_reg  dsig
);

    // funct field of the special opcode
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_slt  = 6'h2a;

    always_comb begin
        // anything not matched below stays a nop
        dsig = '0;
        case (dinstrinf.opcode)
            cpu_pkg::op_special: begin
                dsig.regwrite  = 1'b1;
                dsig.regdst_rd = 1'b1;
                case (dinstrinf.funct)
                    funct_addu: dsig.alu_op = cpu_pkg::alu_add;
                    funct_subu: dsig.alu_op = cpu_pkg::alu_sub;
                    funct_and:  dsig.alu_op = cpu_pkg::alu_and;
                    funct_or:   dsig.alu_op = cpu_pkg::alu_or;
                    funct_slt:  dsig.alu_op = cpu_pkg::alu_slt;
                    default:    dsig = '0;
                endcase
            end
            cpu_pkg::op_addiu: begin
                dsig.regwrite   = 1'b1;
                dsig.alusrc_imm = 1'b1;
            end
            cpu_pkg::op_lw: begin
                dsig.regwrite   = 1'b1;
                dsig.memread    = 1'b1;
                dsig.alusrc_imm = 1'b1;
            end
            cpu_pkg::op_sw: begin
                dsig.memwrite   = 1'b1;
                dsig.alusrc_imm = 1'b1;
            end
            // compare happens in decode, the alu stays idle
            cpu_pkg::op_beq: dsig.branch = cpu_pkg::br_eq;
            cpu_pkg::op_bne: dsig.branch = cpu_pkg::br_ne;
            default: dsig = '0;
        endcase
        // an immediate-form write to r0 does nothing
        if (!dsig.regdst_rd && dinstrinf.rt == 5'd0) begin
            dsig.regwrite = 1'b0;
        end
    end

endmodule

// File: logic/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } mips_op_t;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_eq   = 2'd1,
        br_ne   = 2'd2
    } branch_t;

    // operand source picked by the hazard unit
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_wb   = 2'b01,
        fwd_mem  = 2'b10
    } fwd_sel_t;

    // all zero is a bubble
    typedef struct packed {
        logic    regwrite;
        logic    memread;
        logic    memwrite;
        logic    alusrc_imm;
        logic    regdst_rd;
        alu_op_t alu_op;
        branch_t branch;
    } ctrl_reg;

    typedef struct packed {
        mips_op_t   opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [5:0] funct;
    } instr_inf;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;
    } dp_ftod;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [4:0]           rs;
        logic [4:0]           rt;
        logic [4:0]           reg_waddr;
        logic [`CPU_XLEN-1:0] rsdata;
        logic [`CPU_XLEN-1:0] rtdata;
        logic [`CPU_XLEN-1:0] imm;
    } dp_dtoe;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] ex_out;
        logic [`CPU_XLEN-1:0] wdata;
        logic [4:0]           reg_waddr;
    } dp_etom;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] ex_out;
        logic [4:0]           reg_waddr;
    } dp_mtow;

    // per-stage view handed to the hazard unit
    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] reg_waddr;
        logic       regwrite;
        logic       memread;
        branch_t    branch;
    } dp_stoh;

    typedef struct packed {
        fwd_sel_t forwarda;
        fwd_sel_t forwardb;
    } dp_htod;

    typedef struct packed {
        fwd_sel_t forwarda;
        fwd_sel_t forwardb;
    } dp_htoe;

    typedef struct packed {
        logic f;
        logic d;
        logic e;
        logic m;
        logic w;
    } stage_val_1;

    typedef struct packed {
        logic                 req;
        logic                 wr;
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [3:0]           rf_wen;
        logic [4:0]           rf_wnum;
        logic [`CPU_XLEN-1:0] rf_wdata;
    } wb_debug_t;

endpackage

// File: logic/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path and address width, one word
`define CPU_XLEN 32

// architectural register count
`define CPU_NREGS 32

// first fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: logic/cpu_top.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module cpu_top (
    input  logic                 clk,
    input  logic                 reset,
    output logic [`CPU_XLEN-1:0] f_pc,
    input  logic [`CPU_XLEN-1:0] f_instr,
    output cpu_pkg::dmem_req_t   dmem,
    input  logic [`CPU_XLEN-1:0] m_data_rdata,
    output cpu_pkg::wb_debug_t   wb_debug
);

    // decode-stage fields out, control record back
    cpu_pkg::instr_inf dinstrinf;
    cpu_pkg::ctrl_reg  dsig;

    controller ctrl (
        .dinstrinf(dinstrinf),
        .dsig     (dsig)
    );

    datapath dp (
        .clk         (clk),
        .reset       (reset),
        .dsig        (dsig),
        .dinstrinf   (dinstrinf),
        .f_pc        (f_pc),
        .f_instr     (f_instr),
        .dmem        (dmem),
        .m_data_rdata(m_data_rdata),
        .wb_debug    (wb_debug)
    );

endmodule

// File: logic/datapath.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module datapath (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu_pkg::ctrl_reg     dsig,
    output cpu_pkg::instr_inf    dinstrinf,
    output logic [`CPU_XLEN-1:0] f_pc,
    input  logic [`CPU_XLEN-1:0] f_instr,
    output cpu_pkg::dmem_req_t   dmem,
    input  logic [`CPU_XLEN-1:0] m_data_rdata,
    output cpu_pkg::wb_debug_t   wb_debug
);

    cpu_pkg::dp_ftod     ftod_f, ftod_d;
    cpu_pkg::dp_dtoe     dtoe_d, dtoe_e;
    cpu_pkg::dp_etom     etom_e, etom_m;
    cpu_pkg::dp_mtow     mtow_m, mtow_w;
    cpu_pkg::ctrl_reg    esig, msig, wsig;
    cpu_pkg::dp_stoh     d_hz, e_hz, m_hz, w_hz;
    cpu_pkg::dp_htod     htod;
    cpu_pkg::dp_htoe     htoe;
    cpu_pkg::stage_val_1 stall, flush;

    logic [`CPU_XLEN-1:0] pc_next, br_target;
    logic [`CPU_XLEN-1:0] d_rsdata, d_rtdata, d_rs_fwd, d_rt_fwd;
    logic [`CPU_XLEN-1:0] e_rs_fwd, e_rt_fwd, alu_b;
    logic [`CPU_XLEN-1:0] w_reg_wdata;
    logic                 br_taken;

    function automatic logic [`CPU_XLEN-1:0] fwd_mux(
        input cpu_pkg::fwd_sel_t    sel,
        input logic [`CPU_XLEN-1:0] rf_val,
        input logic [`CPU_XLEN-1:0] wb_val,
        input logic [`CPU_XLEN-1:0] mem_val
    );
        case (sel)
            cpu_pkg::fwd_wb:  return wb_val;
            cpu_pkg::fwd_mem: return mem_val;
            default:          return rf_val;
        endcase
    endfunction

    // fetch, a taken branch in decode redirects past its delay slot
    assign pc_next      = br_taken ? br_target : f_pc + 4;
    assign ftod_f.pc    = f_pc;
    assign ftod_f.instr = f_instr;

    always_ff @(posedge clk) begin
        if (reset) begin
            f_pc <= `CPU_RESET_PC;
        end else if (!stall.f) begin
            f_pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush.d) begin
            ftod_d <= '0;
        end else if (!stall.d) begin
            ftod_d <= ftod_f;
        end
    end

    // decode
    assign dinstrinf.opcode = cpu_pkg::mips_op_t'(ftod_d.instr[31:26]);
    assign dinstrinf.rs     = ftod_d.instr[25:21];
    assign dinstrinf.rt     = ftod_d.instr[20:16];
    assign dinstrinf.funct  = ftod_d.instr[5:0];

    regfile rf (
        .clk          (clk),
        .reset        (reset),
        .regwrite_en  (wsig.regwrite),
        .regwrite_addr(mtow_w.reg_waddr),
        .regwrite_data(w_reg_wdata),
        .rs_addr      (dinstrinf.rs),
        .rt_addr      (dinstrinf.rt),
        .rs_data      (d_rsdata),
        .rt_data      (d_rtdata)
    );

    assign d_rs_fwd = fwd_mux(htod.forwarda, d_rsdata, w_reg_wdata, etom_m.ex_out);
    assign d_rt_fwd = fwd_mux(htod.forwardb, d_rtdata, w_reg_wdata, etom_m.ex_out);

    assign dtoe_d.pc        = ftod_d.pc;
    assign dtoe_d.rs        = dinstrinf.rs;
    assign dtoe_d.rt        = dinstrinf.rt;
    assign dtoe_d.reg_waddr = dsig.regdst_rd ? ftod_d.instr[15:11] : dinstrinf.rt;
    assign dtoe_d.rsdata    = d_rsdata;
    assign dtoe_d.rtdata    = d_rtdata;
    assign dtoe_d.imm       = {{(`CPU_XLEN-16){ftod_d.instr[15]}}, ftod_d.instr[15:0]};

    // target is relative to the delay slot
    assign br_target = ftod_d.pc + 4 + (dtoe_d.imm << 2);
    assign br_taken  = (dsig.branch == cpu_pkg::br_eq && d_rs_fwd == d_rt_fwd) ||
                       (dsig.branch == cpu_pkg::br_ne && d_rs_fwd != d_rt_fwd);

    always_ff @(posedge clk) begin
        if (reset || flush.e) begin
            dtoe_e <= '0;
            esig   <= '0;
        end else if (!stall.e) begin
            dtoe_e <= dtoe_d;
            esig   <= dsig;
        end
    end

    // execute
    assign e_rs_fwd = fwd_mux(htoe.forwarda, dtoe_e.rsdata, w_reg_wdata, etom_m.ex_out);
    assign e_rt_fwd = fwd_mux(htoe.forwardb, dtoe_e.rtdata, w_reg_wdata, etom_m.ex_out);
    assign alu_b    = esig.alusrc_imm ? dtoe_e.imm : e_rt_fwd;

    always_comb begin
        case (esig.alu_op)
            cpu_pkg::alu_sub: etom_e.ex_out = e_rs_fwd - alu_b;
            cpu_pkg::alu_and: etom_e.ex_out = e_rs_fwd & alu_b;
            cpu_pkg::alu_or:  etom_e.ex_out = e_rs_fwd | alu_b;
            cpu_pkg::alu_slt: etom_e.ex_out = {{(`CPU_XLEN-1){1'b0}},
                                               $signed(e_rs_fwd) < $signed(alu_b)};
            default:          etom_e.ex_out = e_rs_fwd + alu_b;
        endcase
    end

    assign etom_e.pc        = dtoe_e.pc;
    assign etom_e.wdata     = e_rt_fwd;
    assign etom_e.reg_waddr = dtoe_e.reg_waddr;

    always_ff @(posedge clk) begin
        if (reset || flush.m) begin
            etom_m <= '0;
            msig   <= '0;
        end else if (!stall.m) begin
            etom_m <= etom_e;
            msig   <= esig;
        end
    end

    // memory, one-cycle request on the sram port
    assign dmem.req   = msig.memread || msig.memwrite;
    assign dmem.wr    = msig.memwrite;
    assign dmem.addr  = etom_m.ex_out;
    assign dmem.wdata = etom_m.wdata;

    assign mtow_m.pc        = etom_m.pc;
    assign mtow_m.ex_out    = etom_m.ex_out;
    assign mtow_m.reg_waddr = etom_m.reg_waddr;

    always_ff @(posedge clk) begin
        if (reset || flush.w) begin
            mtow_w <= '0;
            wsig   <= '0;
        end else if (!stall.w) begin
            mtow_w <= mtow_m;
            wsig   <= msig;
        end
    end

    // writeback, load data shows up this cycle
    assign w_reg_wdata = wsig.memread ? m_data_rdata : mtow_w.ex_out;

    assign wb_debug.pc       = mtow_w.pc;
    assign wb_debug.rf_wen   = {4{wsig.regwrite && mtow_w.reg_waddr != 5'd0}};
    assign wb_debug.rf_wnum  = mtow_w.reg_waddr;
    assign wb_debug.rf_wdata = w_reg_wdata;

    // hazard unit view of each stage
    assign d_hz = '{rs: dinstrinf.rs, rt: dinstrinf.rt, reg_waddr: dtoe_d.reg_waddr,
                    regwrite: dsig.regwrite, memread: dsig.memread, branch: dsig.branch};
    assign e_hz = '{rs: dtoe_e.rs, rt: dtoe_e.rt, reg_waddr: dtoe_e.reg_waddr,
                    regwrite: esig.regwrite, memread: esig.memread, branch: esig.branch};
    assign m_hz = '{rs: 5'd0, rt: 5'd0, reg_waddr: etom_m.reg_waddr,
                    regwrite: msig.regwrite, memread: msig.memread, branch: msig.branch};
    assign w_hz = '{rs: 5'd0, rt: 5'd0, reg_waddr: mtow_w.reg_waddr,
                    regwrite: wsig.regwrite, memread: wsig.memread, branch: wsig.branch};

    hazard hz (
        .d_alpha   (d_hz),
        .e_alpha   (e_hz),
        .m_alpha   (m_hz),
        .w_alpha   (w_hz),
        .to_d_alpha(htod),
        .to_e_alpha(htoe),
        .stall     (stall),
        .flush     (flush)
    );

    // the port is word wide, every request stays aligned
    a_dmem_req: assert property (@(posedge clk) disable iff (reset)
        dmem.req |-> dmem.addr[1:0] == 2'b00);

    // read data lasts one cycle, so a load moves straight into writeback
    a_load_wb: assert property (@(posedge clk) disable iff (reset)
        msig.memread |=> wsig.memread);

endmodule

// File: logic/hazard.sv
`timescale 1ns/1ns

module hazard (
    input  cpu_pkg::dp_stoh     d_alpha,
    input  cpu_pkg::dp_stoh     e_alpha,
    input  cpu_pkg::dp_stoh     m_alpha,
    input  cpu_pkg::dp_stoh     w_alpha,
    output cpu_pkg::dp_htod     to_d_alpha,
    output cpu_pkg::dp_htoe     to_e_alpha,
    output cpu_pkg::stage_val_1 stall,
    output cpu_pkg::stage_val_1 flush
);

    logic load_use;
    logic branch_wait;

    // stage x will write register src, r0 never counts
    function automatic logic hits(input logic [4:0] src, input cpu_pkg::dp_stoh x);
        return x.regwrite && x.reg_waddr != 5'd0 && x.reg_waddr == src;
    endfunction

    // nearest producer wins
    function automatic cpu_pkg::fwd_sel_t pick(input logic [4:0] src, input logic use_w);
        if (hits(src, m_alpha)) begin
            return cpu_pkg::fwd_mem;
        end else if (use_w && hits(src, w_alpha)) begin
            return cpu_pkg::fwd_wb;
        end
        return cpu_pkg::fwd_none;
    endfunction

    // decode gets writeback values through the regfile bypass
    always_comb begin
        to_d_alpha.forwarda = pick(d_alpha.rs, 1'b0);
        to_d_alpha.forwardb = pick(d_alpha.rt, 1'b0);
        to_e_alpha.forwarda = pick(e_alpha.rs, 1'b1);
        to_e_alpha.forwardb = pick(e_alpha.rt, 1'b1);
    end

    assign load_use = e_alpha.memread && (hits(d_alpha.rs, e_alpha) || hits(d_alpha.rt, e_alpha));

    // branch operands must be ready in decode, loads need one extra cycle
    assign branch_wait = d_alpha.branch != cpu_pkg::br_none &&
        (hits(d_alpha.rs, e_alpha) || hits(d_alpha.rt, e_alpha) ||
         (m_alpha.memread && (hits(d_alpha.rs, m_alpha) || hits(d_alpha.rt, m_alpha))));

    always_comb begin
        stall   = '0;
        flush   = '0;
        stall.f = load_use || branch_wait;
        stall.d = load_use || branch_wait;
        // held decode instruction must not also enter execute
        flush.e = load_use || branch_wait;
    end

    // load data is not ready in memory, the load-use stall keeps its consumer back
    always_comb begin
        assert (!(m_alpha.memread &&
                  (to_e_alpha.forwarda == cpu_pkg::fwd_mem ||
                   to_e_alpha.forwardb == cpu_pkg::fwd_mem)))
            else $error("hazard: execute operand forwarded from a load in memory");
    end

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 regwrite_en,
    input  logic [4:0]           regwrite_addr,
    input  logic [`CPU_XLEN-1:0] regwrite_data,
    input  logic [4:0]           rs_addr,
    input  logic [4:0]           rt_addr,
    output logic [`CPU_XLEN-1:0] rs_data,
    output logic [`CPU_XLEN-1:0] rt_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // r0 reads zero, a same-cycle write is seen by the reader
    function automatic logic [`CPU_XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (regwrite_en && regwrite_addr == addr) begin
            return regwrite_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regwrite_en && regwrite_addr != 5'd0) begin
            regs[regwrite_addr] <= regwrite_data;
        end
    end

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

// File: verif/tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_settings.svh"

module tb_cpu;

    localparam int ntests      = 5;
    localparam int prog_words  = 256;
    localparam int half_period = 50;
    localparam int drive_delay = 1;

    // funct field of the special opcode
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_slt  = 6'h2a;

    logic                 clk;
    logic                 reset;
    logic [`CPU_XLEN-1:0] f_pc;
    logic [`CPU_XLEN-1:0] f_instr;
    cpu_pkg::dmem_req_t   dmem;
    logic [`CPU_XLEN-1:0] m_data_rdata;
    cpu_pkg::wb_debug_t   wb_debug;

    // one row of program words per test
    logic [31:0] progs [ntests][prog_words];
    int          prog_len [ntests];
    string       test_name [ntests];
    int          cur_prog;
    int          cur_test;

    logic [31:0] imem [1024];
    logic [31:0] dmem_words [256];
    logic [31:0] rd_data;

    cpu_pkg::wb_debug_t exp_wb [$];
    cpu_pkg::dmem_req_t exp_st [$];
    int                 wb_seen;
    int                 st_seen;
    int                 test_errors;
    int                 total_errors;
    int                 tests_passed;
    int                 tests_failed;
    int                 total_instr;
    logic               active;
    logic               programs_built;
    integer             seed;

    cpu_top uut (
        .clk         (clk),
        .reset       (reset),
        .f_pc        (f_pc),
        .f_instr     (f_instr),
        .dmem        (dmem),
        .m_data_rdata(m_data_rdata),
        .wb_debug    (wb_debug)
    );

    always #half_period clk = ~clk;

    // every data word starts out different
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], ~addr[15:0]} ^ {~addr[31:16], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    // in-order ISA model, branch takes effect after its delay slot
    function automatic void run_model(input int t);
        logic [31:0]        regs [32];
        logic [31:0]        mem [256];
        logic [31:0]        pc, npc, nnpc, ins, a, b, imm, addr, val;
        logic [4:0]         dest;
        logic               writes;
        int                 i;
        int                 steps;
        cpu_pkg::wb_debug_t wb;
        cpu_pkg::dmem_req_t st;
        exp_wb.delete();
        exp_st.delete();
        for (i = 0; i < 32; i++) begin
            regs[5'(i)] = '0;
        end
        for (i = 0; i < 256; i++) begin
            mem[8'(i)] = fill_word(32'(i) << 2);
        end
        pc = `CPU_RESET_PC;
        npc = pc + 4;
        steps = 0;
        while (pc < 32'(prog_len[3'(t)] * 4) && steps < 4 * prog_words) begin
            ins = progs[3'(t)][pc[9:2]];
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            imm = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            writes = 1'b0;
            dest = ins[20:16];
            val = '0;
            nnpc = npc + 4;
            case (ins[31:26])
                cpu_pkg::op_special: begin
                    writes = 1'b1;
                    dest = ins[15:11];
                    case (ins[5:0])
                        funct_addu: val = a + b;
                        funct_subu: val = a - b;
                        funct_and:  val = a & b;
                        funct_or:   val = a | b;
                        funct_slt:  val = {31'b0, $signed(a) < $signed(b)};
                        default:    writes = 1'b0;
                    endcase
                end
                cpu_pkg::op_addiu: begin
                    writes = 1'b1;
                    val = addr;
                end
                cpu_pkg::op_lw: begin
                    writes = 1'b1;
                    val = mem[addr[9:2]];
                end
                cpu_pkg::op_sw: begin
                    mem[addr[9:2]] = b;
                    st = '{req: 1'b1, wr: 1'b1, addr: addr, wdata: b};
                    exp_st.push_back(st);
                end
                cpu_pkg::op_beq: if (a == b) nnpc = npc + (imm << 2);
                cpu_pkg::op_bne: if (a != b) nnpc = npc + (imm << 2);
                default: ;
            endcase
            if (writes && dest != 5'd0) begin
                regs[dest] = val;
                wb = '{pc: pc, rf_wen: 4'hf, rf_wnum: dest, rf_wdata: val};
                exp_wb.push_back(wb);
            end
            pc = npc;
            npc = nnpc;
            steps++;
        end
    endfunction

    task automatic check_wb(input string name, input cpu_pkg::wb_debug_t exp,
                            input cpu_pkg::wb_debug_t act);
        if (act !== exp) begin
            $display("error %s: expected pc=%h wen=%h r%0d=%h, actual pc=%h wen=%h r%0d=%h",
                     name, exp.pc, exp.rf_wen, exp.rf_wnum, exp.rf_wdata,
                     act.pc, act.rf_wen, act.rf_wnum, act.rf_wdata);
            test_errors++;
        end
    endtask

    task automatic check_store(input string name, input cpu_pkg::dmem_req_t exp,
                               input cpu_pkg::dmem_req_t act);
        if (act !== exp) begin
            $display("error %s: expected req=%b wr=%b [%h]=%h, actual req=%b wr=%b [%h]=%h",
                     name, exp.req, exp.wr, exp.addr, exp.wdata,
                     act.req, act.wr, act.addr, act.wdata);
            test_errors++;
        end
    endtask

    task automatic check_pc(input string name, input logic [`CPU_XLEN-1:0] exp,
                            input logic [`CPU_XLEN-1:0] act);
        if (act !== exp) begin
            $display("error %s: expected f_pc=%h, actual f_pc=%h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic append_word(input logic [31:0] w);
        progs[3'(cur_prog)][8'(prog_len[3'(cur_prog)])] = w;
        prog_len[3'(cur_prog)]++;
    endtask

    task automatic rtype(input logic [5:0] funct, input int rd, input int rs, input int rt);
        append_word({cpu_pkg::op_special, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct});
    endtask

    task automatic itype(input cpu_pkg::mips_op_t op, input int rt, input int rs,
                         input int imm);
        append_word({op, rs[4:0], rt[4:0], imm[15:0]});
    endtask

    task automatic start_program(input int t, input string name);
        cur_prog = t;
        prog_len[3'(t)] = 0;
        test_name[3'(t)] = name;
    endtask

    task automatic idle_program(input int t);
        int i;
        start_program(t, "reset_idle");
        for (i = 0; i < 8; i++) begin
            append_word('0);
        end
    endtask

    task automatic alu_chain_program(input int t);
        start_program(t, "alu_forwarding");
        itype(cpu_pkg::op_addiu, 1, 0, 5);
        itype(cpu_pkg::op_addiu, 2, 0, -3);
        rtype(funct_addu, 3, 1, 2);
        rtype(funct_subu, 4, 3, 1);
        rtype(funct_and, 5, 4, 3);
        rtype(funct_or, 6, 5, 2);
        rtype(funct_slt, 7, 2, 1);
        rtype(funct_slt, 8, 1, 2);
        itype(cpu_pkg::op_addiu, 9, 7, 16'h7fff);
        // writes to r0 never show up
        rtype(funct_addu, 0, 1, 2);
        rtype(funct_addu, 10, 9, 9);
        rtype(funct_subu, 11, 10, 0);
        itype(cpu_pkg::op_addiu, 0, 9, 1);
    endtask

    task automatic load_store_program(input int t);
        start_program(t, "load_store");
        itype(cpu_pkg::op_addiu, 1, 0, 16'h40);
        itype(cpu_pkg::op_addiu, 2, 0, 16'h1234);
        itype(cpu_pkg::op_sw, 2, 1, 0);
        itype(cpu_pkg::op_addiu, 3, 0, -1);
        itype(cpu_pkg::op_sw, 3, 1, 4);
        itype(cpu_pkg::op_lw, 4, 1, 0);
        // load-use pairs
        rtype(funct_addu, 5, 4, 4);
        itype(cpu_pkg::op_lw, 6, 1, 4);
        itype(cpu_pkg::op_sw, 6, 1, 8);
        itype(cpu_pkg::op_lw, 7, 1, 8);
        itype(cpu_pkg::op_lw, 8, 1, 12);
        rtype(funct_subu, 9, 8, 7);
    endtask

    task automatic branch_program(input int t);
        start_program(t, "branches");
        itype(cpu_pkg::op_addiu, 1, 0, 7);
        itype(cpu_pkg::op_addiu, 2, 0, 7);
        itype(cpu_pkg::op_beq, 2, 1, 2);
        itype(cpu_pkg::op_addiu, 3, 0, 1);
        itype(cpu_pkg::op_addiu, 4, 0, 2);
        itype(cpu_pkg::op_addiu, 5, 0, 3);
        itype(cpu_pkg::op_bne, 2, 1, 2);
        itype(cpu_pkg::op_addiu, 6, 0, 4);
        itype(cpu_pkg::op_addiu, 7, 0, 5);
        itype(cpu_pkg::op_sw, 1, 0, 16'h80);
        itype(cpu_pkg::op_lw, 8, 0, 16'h80);
        // operand straight from the load
        itype(cpu_pkg::op_bne, 0, 8, 3);
        itype(cpu_pkg::op_addiu, 9, 0, 6);
        itype(cpu_pkg::op_addiu, 10, 0, 8);
        itype(cpu_pkg::op_addiu, 11, 0, 9);
        itype(cpu_pkg::op_addiu, 12, 0, 10);
        itype(cpu_pkg::op_beq, 0, 12, 1);
        rtype(funct_addu, 13, 12, 5);
        rtype(funct_subu, 14, 13, 12);
        itype(cpu_pkg::op_beq, 5, 14, 2);
        rtype(funct_or, 15, 14, 12);
        itype(cpu_pkg::op_addiu, 16, 0, 11);
        itype(cpu_pkg::op_addiu, 17, 0, 12);
    endtask

    task automatic random_program(input int t);
        logic [31:0] rnd;
        int          i;
        int          kind;
        int          rd;
        int          rs;
        int          rt;
        start_program(t, "random_alu");
        for (i = 0; i < 200; i++) begin
            rnd = $random(seed);
            kind = int'(rnd[2:0]) % 6;
            rd = int'(rnd[5:3]);
            rs = int'(rnd[8:6]);
            rt = int'(rnd[11:9]);
            case (kind)
                0: rtype(funct_addu, rd, rs, rt);
                1: rtype(funct_subu, rd, rs, rt);
                2: rtype(funct_and, rd, rs, rt);
                3: rtype(funct_or, rd, rs, rt);
                4: rtype(funct_slt, rd, rs, rt);
                default: itype(cpu_pkg::op_addiu, rd, rs, int'(rnd[31:16]));
            endcase
        end
    endtask

    // instruction and read data go out just after the edge
    always @(posedge clk) begin
        #drive_delay;
        f_instr = imem[f_pc[11:2]];
        m_data_rdata = rd_data;
    end

    // compare process, sampled mid-cycle while outputs are stable
    always @(negedge clk) begin
        if (!reset && active) begin
            if (dmem.req && dmem.wr) begin
                dmem_words[dmem.addr[9:2]] = dmem.wdata;
                if (st_seen < exp_st.size()) begin
                    check_store(test_name[3'(cur_test)], exp_st[st_seen], dmem);
                end else begin
                    $display("test %s: unexpected store of %h to address %h",
                             test_name[3'(cur_test)], dmem.wdata, dmem.addr);
                    test_errors++;
                end
                st_seen++;
            end else if (dmem.req) begin
                rd_data = dmem_words[dmem.addr[9:2]];
            end
            if (wb_debug.rf_wen != 4'h0) begin
                if (wb_seen < exp_wb.size()) begin
                    check_wb(test_name[3'(cur_test)], exp_wb[wb_seen], wb_debug);
                end else begin
                    $display("test %s: unexpected writeback to r%0d from pc %h",
                             test_name[3'(cur_test)], wb_debug.rf_wnum, wb_debug.pc);
                    test_errors++;
                end
                wb_seen++;
            end
        end
    end

    task automatic run_test(input int t);
        logic [31:0] end_pc;
        int          i;
        @(posedge clk);
        #drive_delay;
        reset = 1'b1;
        active = 1'b0;
        cur_test = t;
        for (i = 0; i < 1024; i++) begin
            imem[10'(i)] = (i < prog_words) ? progs[3'(t)][8'(i)] : '0;
        end
        for (i = 0; i < 256; i++) begin
            dmem_words[8'(i)] = fill_word(32'(i) << 2);
        end
        run_model(t);
        wb_seen = 0;
        st_seen = 0;
        test_errors = 0;
        rd_data = '0;
        // past the last word by enough for it to retire
        end_pc = 32'(prog_len[3'(t)] * 4 + 20);
        repeat (2) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        active = 1'b1;
        @(negedge clk);
        check_pc(test_name[3'(t)], `CPU_RESET_PC, f_pc);
        check_wb(test_name[3'(t)], '0, wb_debug);
        check_store(test_name[3'(t)], '0, dmem);
        while (!(wb_seen >= exp_wb.size() && st_seen >= exp_st.size() && f_pc >= end_pc)) begin
            @(posedge clk);
            #drive_delay;
        end
        $display("test %s: %0d writebacks, %0d stores, %0d errors, %s", test_name[3'(t)],
                 wb_seen, st_seen, test_errors, (test_errors == 0) ? "passed" : "failed");
        total_errors += test_errors;
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
    endtask

    initial begin
        int t;
        int i;
        clk = 1'b0;
        reset = 1'b1;
        f_instr = '0;
        m_data_rdata = '0;
        rd_data = '0;
        active = 1'b0;
        programs_built = 1'b0;
        seed = 32'h3a40_38c1;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (t = 0; t < ntests; t++) begin
            for (i = 0; i < prog_words; i++) begin
                progs[3'(t)][8'(i)] = '0;
            end
        end
        idle_program(0);
        alu_chain_program(1);
        load_store_program(2);
        branch_program(3);
        random_program(4);
        total_instr = 0;
        for (t = 0; t < ntests; t++) begin
            total_instr += prog_len[3'(t)];
        end
        programs_built = 1'b1;
        for (t = 0; t < ntests; t++) begin
            run_test(t);
        end
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // budget of 20 cycles per instruction over all programs
    initial begin
        wait (programs_built == 1'b1);
        repeat (20 * total_instr) @(posedge clk);
        $display("timeout in test %s: %0d of %0d writebacks and %0d of %0d stores arrived",
                 test_name[3'(cur_test)], wb_seen, exp_wb.size(), st_seen, exp_st.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
